// File: warpPkg.sv
package warpPkg;

	// memory map decoded on address bits 23..20
	// RAM covers 0x000000 to 0x3FFFFF and ROM covers 0x400000 to 0x4FFFFF
	localparam logic [3:0] ramTop = 4'h3;
	localparam logic [3:0] romRegion = 4'h4;

	// bus cycle timing in fclk cycles
	localparam int romWaitStates = 2;
	localparam int refreshPeriod = 64;
	localparam int berrDelay = 1;

	// counter widths derived from the timing values above
	localparam int romCntWidth = $clog2(romWaitStates + 1);
	localparam int refCntWidth = $clog2(refreshPeriod);
	localparam int berrCntWidth = $clog2(berrDelay + 1);

	// one processor request as seen on the pins
	// write is active high here and the strobes keep their bus polarity
	typedef struct packed {
		logic [23:1] addr;
		logic write;
		logic udsN;
		logic ldsN;
	} fsbReq_t;

	// device selects held for the length of one bus cycle
	typedef struct packed {
		logic ramCs;
		logic romCs;
		logic unmappedCs;
	} chipSel_t;

	// DRAM pins driven by the RAM controller
	typedef struct packed {
		logic [10:0] ra;
		logic rasN;
		logic casN;
		logic lweN;
		logic uweN;
		logic oeN;
	} dramBus_t;

	// DRAM sequencer states for access and CAS-before-RAS refresh
	typedef enum logic [2:0] {
		ramIdle,
		ramRow,
		ramCas,
		refCas,
		refRas,
		refHold,
		ramPrecharge
	} ramState_t;

	// bus cycle termination states
	typedef enum logic [1:0] {
		fsbIdle,
		fsbWait,
		fsbAck,
		fsbErr
	} fsbState_t;

endpackage

// File: chipSelect.sv
module chipSelect import warpPkg::*; (
	input logic fclk,
	input logic reset,
	input logic busStart,
	input logic busActive,
	input fsbReq_t req,
	output chipSel_t sel
);

	// the upper nibble of the address picks the region
	logic [3:0] region;
	logic inRam;
	logic inRom;

	// ROM sits at address zero until the first ROM-region access
	logic overlay;
	chipSel_t selNext;

	assign region = req.addr[23:20];
	assign inRam = (region <= ramTop);
	assign inRom = (region == romRegion);

	// while overlay is set the RAM region is answered by ROM
	always_comb begin
		selNext.ramCs = inRam && !overlay;
		selNext.romCs = inRom || (inRam && overlay);
		selNext.unmappedCs = !inRam && !inRom;
	end

	// the selects are captured once at cycle start and held
	// they drop one edge after busActive falls so the next cycle starts clean
	always_ff @(posedge fclk) begin
		if (reset) begin
			sel <= '0;
		end else if (busStart) begin
			sel <= selNext;
		end else if (!busActive) begin
			sel <= '0;
		end
	end

	// reset maps ROM over the bottom of memory
	// any access to the real ROM region removes the mirror for good
	always_ff @(posedge fclk) begin
		if (reset) begin
			overlay <= 1'b1;
		end else if (busStart && inRom) begin
			overlay <= 1'b0;
		end
	end

endmodule

// File: refreshTimer.sv
module refreshTimer import warpPkg::*; (
	input logic fclk,
	input logic reset,
	input logic refAck,
	output logic refReq
);

	// free-running period counter
	logic [refCntWidth-1:0] refCnt;
	logic refWrap;

	assign refWrap = (refCnt == refCntWidth'(refreshPeriod - 1));

	// the counter never stops, so refresh requests stay evenly spaced
	// even when the RAM controller is slow to take one
	always_ff @(posedge fclk) begin
		if (reset) begin
			refCnt <= '0;
		end else if (refWrap) begin
			refCnt <= '0;
		end else begin
			refCnt <= refCnt + 1'b1;
		end
	end

	// the request is a level until the controller acknowledges it
	// a wrap while still pending just leaves it set
	// a wrap wins over an acknowledge in the same cycle
	always_ff @(posedge fclk) begin
		if (reset) begin
			refReq <= 1'b0;
		end else if (refWrap) begin
			refReq <= 1'b1;
		end else if (refAck) begin
			refReq <= 1'b0;
		end
	end

endmodule

// File: ramController.sv
module ramController import warpPkg::*; (
	input logic fclk,
	input logic reset,
	input logic busStart,
	input logic busActive,
	input fsbReq_t req,
	input chipSel_t sel,
	input logic refReq,
	output logic refAck,
	output logic memReady,
	output dramBus_t dram,
	output logic romOeN
);

	ramState_t state;
	ramState_t stateNext;
	dramBus_t dramNext;

	// row and column halves of the word address
	logic [10:0] rowAddr;
	logic [10:0] colAddr;

	// counts cycles of a ROM access towards memReady
	logic [romCntWidth-1:0] romWait;

	assign rowAddr = req.addr[21:11];
	assign colAddr = {1'b0, req.addr[10:1]};

	// refresh is only started from idle
	// an access that has already dropped RAS is never cut short
	always_comb begin
		stateNext = state;
		case (state)
			ramIdle: begin
				if (refReq) begin
					stateNext = refCas;
				end else if (busActive && sel.ramCs) begin
					stateNext = ramRow;
				end
			end
			ramRow: stateNext = ramCas;
			// CAS stays low until the processor ends the cycle
			ramCas: begin
				if (!busActive) begin
					stateNext = ramPrecharge;
				end
			end
			refCas: stateNext = refRas;
			refRas: stateNext = refHold;
			refHold: stateNext = ramPrecharge;
			ramPrecharge: stateNext = ramIdle;
			default: stateNext = ramIdle;
		endcase
	end

	// pin values for the state being entered so the strobes come straight off flops
	always_comb begin
		dramNext.ra = rowAddr;
		dramNext.rasN = 1'b1;
		dramNext.casN = 1'b1;
		dramNext.lweN = 1'b1;
		dramNext.uweN = 1'b1;
		dramNext.oeN = 1'b1;
		case (stateNext)
			ramRow: begin
				dramNext.rasN = 1'b0;
			end
			ramCas: begin
				dramNext.ra = colAddr;
				dramNext.rasN = 1'b0;
				dramNext.casN = 1'b0;
				// reads open the output buffers and writes strobe the byte lanes
				dramNext.oeN = req.write;
				dramNext.lweN = req.write ? req.ldsN : 1'b1;
				dramNext.uweN = req.write ? req.udsN : 1'b1;
			end
			// CAS leads RAS for a refresh and both are held one extra cycle
			refCas: begin
				dramNext.casN = 1'b0;
			end
			refRas, refHold: begin
				dramNext.rasN = 1'b0;
				dramNext.casN = 1'b0;
			end
			default: begin
				dramNext.rasN = 1'b1;
			end
		endcase
	end

	always_ff @(posedge fclk) begin
		if (reset) begin
			state <= ramIdle;
			dram <= '{ra: '0, rasN: 1'b1, casN: 1'b1, lweN: 1'b1, uweN: 1'b1, oeN: 1'b1};
			refAck <= 1'b0;
		end else begin
			state <= stateNext;
			dram <= dramNext;
			// one pulse as the refresh sequence begins
			refAck <= (state == ramIdle) && (stateNext == refCas);
		end
	end

	// ROM wait count restarts with each cycle and saturates
	always_ff @(posedge fclk) begin
		if (reset) begin
			romWait <= '0;
		end else if (busStart) begin
			romWait <= '0;
		end else if (busActive && sel.romCs && romWait != romCntWidth'(romWaitStates)) begin
			romWait <= romWait + 1'b1;
		end
	end

	// ROM output enable only for reads and only while the cycle lasts
	always_ff @(posedge fclk) begin
		if (reset) begin
			romOeN <= 1'b1;
		end else if (!busActive) begin
			romOeN <= 1'b1;
		end else if (sel.romCs && !req.write) begin
			romOeN <= 1'b0;
		end
	end

	// memReady rises with CAS for RAM or after the ROM wait states
	// it then holds until the processor releases the bus
	always_ff @(posedge fclk) begin
		if (reset) begin
			memReady <= 1'b0;
		end else if (!busActive) begin
			memReady <= 1'b0;
		end else if (state == ramRow && stateNext == ramCas) begin
			memReady <= 1'b1;
		end else if (sel.romCs && romWait == romCntWidth'(romWaitStates - 1)) begin
			memReady <= 1'b1;
		end
	end

endmodule

// File: fsbController.sv
module fsbController import warpPkg::*; (
	input logic fclk,
	input logic reset,
	input logic asN,
	input chipSel_t sel,
	input logic memReady,
	output logic busStart,
	output logic busActive,
	output logic dtackN,
	output logic berrN
);

	// asN as seen at the last edge
	logic asNr;

	fsbState_t state;
	fsbState_t stateNext;

	// cycles spent waiting on an unmapped select
	logic [berrCntWidth-1:0] berrCnt;

	assign busActive = !asNr;

	// busStart marks the first edge that sees the address strobe low
	always_ff @(posedge fclk) begin
		if (reset) begin
			asNr <= 1'b1;
			busStart <= 1'b0;
		end else begin
			asNr <= asN;
			busStart <= !asN && asNr;
		end
	end

	// a cycle ends in an acknowledge or a bus error
	// either one is held until the processor drops the strobe
	always_comb begin
		stateNext = state;
		case (state)
			fsbIdle: begin
				if (busStart) begin
					stateNext = fsbWait;
				end
			end
			fsbWait: begin
				if (!busActive) begin
					stateNext = fsbIdle;
				end else if (memReady) begin
					stateNext = fsbAck;
				end else if (sel.unmappedCs && berrCnt == berrCntWidth'(berrDelay)) begin
					stateNext = fsbErr;
				end
			end
			fsbAck, fsbErr: begin
				if (!busActive) begin
					stateNext = fsbIdle;
				end
			end
			default: stateNext = fsbIdle;
		endcase
	end

	// termination outputs are registered off the next state
	always_ff @(posedge fclk) begin
		if (reset) begin
			state <= fsbIdle;
			dtackN <= 1'b1;
			berrN <= 1'b1;
		end else begin
			state <= stateNext;
			dtackN <= (stateNext != fsbAck);
			berrN <= (stateNext != fsbErr);
		end
	end

	// the error delay counts from the first wait cycle and then stops
	always_ff @(posedge fclk) begin
		if (reset) begin
			berrCnt <= '0;
		end else if (state != fsbWait) begin
			berrCnt <= '0;
		end else if (berrCnt != berrCntWidth'(berrDelay)) begin
			berrCnt <= berrCnt + 1'b1;
		end
	end

endmodule

// File: warpTop.sv
module warpTop import warpPkg::*; (
	input logic fclk,
	input logic reset,
	input logic asN,
	input logic udsN,
	input logic ldsN,
	input logic writeN,
	input logic [23:1] addr,
	output logic dtackN,
	output logic berrN,
	output logic [10:0] ra,
	output logic rasN,
	output logic casN,
	output logic lweN,
	output logic uweN,
	output logic oeN,
	output logic romOeN
);

	fsbReq_t req;
	chipSel_t sel;
	dramBus_t dram;

	// cycle detection and handshakes between the blocks
	logic busStart;
	logic busActive;
	logic memReady;
	logic refReq;
	logic refAck;

	// the request comes straight from the processor pins
	// write is carried active high inside the design
	assign req = '{addr: addr, write: !writeN, udsN: udsN, ldsN: ldsN};

	assign ra = dram.ra;
	assign rasN = dram.rasN;
	assign casN = dram.casN;
	assign lweN = dram.lweN;
	assign uweN = dram.uweN;
	assign oeN = dram.oeN;

	chipSelect chipSelect_i (
		.fclk(fclk), .reset(reset), .busStart(busStart), .busActive(busActive),
		.req(req), .sel(sel));

	refreshTimer refreshTimer_i (
		.fclk(fclk), .reset(reset), .refAck(refAck), .refReq(refReq));

	ramController ramController_i (
		.fclk(fclk), .reset(reset), .busStart(busStart), .busActive(busActive),
		.req(req), .sel(sel), .refReq(refReq), .refAck(refAck),
		.memReady(memReady), .dram(dram), .romOeN(romOeN));

	fsbController fsbController_i (
		.fclk(fclk), .reset(reset), .asN(asN), .sel(sel), .memReady(memReady),
		.busStart(busStart), .busActive(busActive), .dtackN(dtackN), .berrN(berrN));

endmodule

// File: fsb_checker.sv
module warpChecker import warpPkg::*; (
	input logic fclk, reset, asN, udsN, ldsN, writeN,
	input logic [23:1] addr,
	input logic dtackN, berrN,
	input logic [10:0] ra,
	input logic rasN, casN, lweN, uweN, oeN, romOeN
);

	// a refresh has to start within one period plus the longest bus cycle
	localparam int refWindow = refreshPeriod + 16;

	// first failure kept for the testbench to report
	int failCount = 0;
	string failName = "";
	logic [31:0] failGot;
	logic [31:0] failExp;

	logic [3:0] region;
	logic asPrev, cycleStart, rasPrev, romSeen;
	logic ramCycle, unmappedCycle, accessRas, inRefresh;
	logic expRam, expRom, expUnmapped, accessFall, refreshing;
	logic [14:0] casGot, casExp;
	logic [2:0] idleGot;
	int refGap;

	// expected decode from the memory map, ROM mirrored low until ROM is touched
	assign region = addr[23:20];
	assign expRam = (region <= ramTop) && romSeen;
	assign expRom = (region == romRegion) || ((region <= ramTop) && !romSeen);
	assign expUnmapped = !expRam && !expRom;

	// an access drops RAS with CAS still high, a refresh drops CAS first
	assign accessFall = rasPrev && !rasN && casN;
	assign refreshing = (rasN && !casN) || inRefresh;
	assign casGot = {casN, oeN, uweN, lweN, ra};
	assign casExp = {1'b0, writeN ? 3'b011 : {1'b1, udsN, ldsN}, 1'b0, addr[10:1]};
	assign idleGot = {dtackN, berrN, (rasN && casN) || refreshing};

	task automatic noteFail(input string name, input logic [31:0] got, input logic [31:0] exp);
		$error("%s check failed", name);
		if (failCount == 0) begin
			failName = name;
			failGot = got;
			failExp = exp;
		end
		failCount++;
	endtask

	// cycle start is the first edge after the one that saw the strobe fall
	always_ff @(posedge fclk) begin
		if (reset) begin
			asPrev <= 1'b1;
			cycleStart <= 1'b0;
			rasPrev <= 1'b1;
			romSeen <= 1'b0;
			ramCycle <= 1'b0;
			unmappedCycle <= 1'b0;
			accessRas <= 1'b0;
			inRefresh <= 1'b0;
			refGap <= 0;
		end else begin
			asPrev <= asN;
			cycleStart <= asPrev && !asN;
			rasPrev <= rasN;
			if (cycleStart && region == romRegion) begin
				romSeen <= 1'b1;
			end
			if (cycleStart) begin
				ramCycle <= expRam;
				unmappedCycle <= expUnmapped;
				accessRas <= 1'b0;
			end else if (accessFall) begin
				accessRas <= 1'b1;
			end
			// a refresh lasts from its CAS fall until CAS rises again
			inRefresh <= refreshing && !casN;
			refGap <= (rasN && !casN) ? 0 : refGap + 1;
		end
	end

	assert property (@(posedge fclk) disable iff (reset) cycleStart && expRom |-> ##2 (romOeN == !writeN))
		else noteFail("romOeN", $sampled(romOeN), !$sampled(writeN));
	assert property (@(posedge fclk) disable iff (reset)
		cycleStart && expRom |-> ##(romWaitStates + 1) dtackN ##1 !dtackN)
		else noteFail("dtackN", $sampled(dtackN), !$sampled(dtackN));
	assert property (@(posedge fclk) disable iff (reset)
		cycleStart && expUnmapped |-> ##(berrDelay + 1) berrN ##1 !berrN)
		else noteFail("berrN", $sampled(berrN), !$sampled(berrN));
	// an unmapped cycle never acknowledges and a mapped one never errors
	assert property (@(posedge fclk) disable iff (reset) unmappedCycle |-> dtackN)
		else noteFail("dtackN", $sampled(dtackN), 1'b1);
	assert property (@(posedge fclk) disable iff (reset) !unmappedCycle |-> berrN)
		else noteFail("berrN", $sampled(berrN), 1'b1);
	// row on the RAS fall, column and strobes on the CAS fall, dtackN one cycle later
	assert property (@(posedge fclk) disable iff (reset) accessFall |-> ra == addr[21:11])
		else noteFail("ra", $sampled(ra), $sampled(addr[21:11]));
	assert property (@(posedge fclk) disable iff (reset) accessFall |=> casGot == casExp)
		else noteFail("casN,oeN,uweN,lweN,ra", $sampled(casGot), $sampled(casExp));
	assert property (@(posedge fclk) disable iff (reset) accessFall |=> ##1 $fell(dtackN))
		else noteFail("dtackN", $sampled(dtackN), 1'b0);
	assert property (@(posedge fclk) disable iff (reset) $fell(rasN) && !casN |-> !$past(casN))
		else noteFail("casN", $past(casN), 1'b0);
	assert property (@(posedge fclk) disable iff (reset) $rose(rasN) |=> rasN)
		else noteFail("rasN", $sampled(rasN), 1'b1);
	assert property (@(posedge fclk) disable iff (reset) refGap < refWindow)
		else noteFail("refresh gap", $sampled(refGap), refWindow);
	// RAS access strobes appear in exactly the cycles that map to RAM
	assert property (@(posedge fclk) disable iff (reset) $rose(asN) |-> accessRas == ramCycle)
		else noteFail("rasN access", $sampled(accessRas), $sampled(ramCycle));
	assert property (@(posedge fclk) disable iff (reset)
		asN && $past(asN) && $past(asN, 2) |-> idleGot == 3'b111)
		else noteFail("dtackN,berrN,rasN/casN", $sampled(idleGot), 3'b111);

endmodule

bind warpTop warpChecker warpChecker_i (.*);

// File: warpTb.sv
module warpTb import warpPkg::*; ();

	logic fclk;
	logic reset;
	logic asN;
	logic udsN;
	logic ldsN;
	logic writeN;
	logic [23:1] addr;
	logic dtackN;
	logic berrN;
	logic [10:0] ra;
	logic rasN, casN, lweN, uweN, oeN, romOeN;

	// shift register behind every address and strobe pattern
	logic [31:0] lfsr = 32'ha470c7ba;

	warpTop warpTop_i (.*);

	initial fclk = 1'b0;
	always #50 fclk = !fclk;

	// Fibonacci taps 32, 22, 2 and 1, one step per bit taken
	function automatic logic [31:0] takeBits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			value = {value[30:0], lfsr[0]};
		end
		return value;
	endfunction

	// kinds 0 and 1 pick RAM, 2 picks ROM and 3 anything above ROM
	function automatic logic [23:1] randomAddr(input logic [31:0] kind);
		logic [3:0] region;
		logic [31:0] low;
		case (kind)
			0, 1: region = 4'(takeBits(4) % (ramTop + 1));
			2: region = romRegion;
			default: region = 4'(romRegion + 1 + takeBits(4) % (15 - romRegion));
		endcase
		low = takeBits(19);
		return {region, low[18:0]};
	endfunction

	// one processor cycle, ended as soon as dtackN or berrN answers
	task automatic busCycle(input logic [23:1] cycleAddr, input logic write);
		logic [31:0] lanes;
		int waited;
		lanes = takeBits(2);
		// reads use both byte lanes, writes one or both
		if (!write || lanes[1:0] == 2'b11) begin
			lanes = '0;
		end
		@(negedge fclk);
		addr = cycleAddr;
		writeN = !write;
		udsN = lanes[1];
		ldsN = lanes[0];
		asN = 1'b0;
		waited = 0;
		while (dtackN && berrN && waited < 20) begin
			@(negedge fclk);
			waited++;
		end
		if (dtackN && berrN) begin
			$display("no acknowledge or bus error for the cycle at %h", {cycleAddr, 1'b0});
			$display("TESTS FAILED");
			$fatal(1);
		end
		asN = 1'b1;
		udsN = 1'b1;
		ldsN = 1'b1;
		waited = 0;
		while ((!dtackN || !berrN) && waited < 5) begin
			@(negedge fclk);
			waited++;
		end
		if (!dtackN || !berrN) begin
			$display("dtackN or berrN still low after the cycle at %h ended", {cycleAddr, 1'b0});
			$display("TESTS FAILED");
			$fatal(1);
		end
	endtask

	always @(negedge fclk) begin
		if (warpTop_i.warpChecker_i.failCount != 0) begin
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", warpTop_i.warpChecker_i.failName,
				warpTop_i.warpChecker_i.failGot, warpTop_i.warpChecker_i.failExp);
			$display("TESTS FAILED");
			$fatal(1);
		end
	end

	initial begin
		logic [23:1] firstAddr;
		logic [31:0] kind;
		logic write;
		reset = 1'b1;
		asN = 1'b1;
		udsN = 1'b1;
		ldsN = 1'b1;
		writeN = 1'b1;
		addr = '0;
		repeat (3) @(negedge fclk);
		reset = 1'b0;
		// low addresses answer from the ROM mirror until the ROM region is used
		firstAddr = randomAddr(0);
		busCycle(firstAddr, 1'b0);
		busCycle(randomAddr(1), 1'b1);
		busCycle(randomAddr(3), 1'b0);
		busCycle(randomAddr(2), 1'b0);
		// the same address now runs a real DRAM cycle
		busCycle(firstAddr, 1'b0);
		busCycle(randomAddr(2), 1'b1);
		for (int i = 0; i < 60; i++) begin
			kind = takeBits(2);
			write = (takeBits(1) != 0);
			busCycle(randomAddr(kind), write);
		end
		// an idle bus still has to see refresh
		repeat (2 * refreshPeriod) @(negedge fclk);
		if (warpTop_i.warpChecker_i.failCount == 0) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			$display("TESTS FAILED");
			$fatal(1);
		end
	end

endmodule

// File: flist.f
warpPkg.sv
chipSelect.sv
refreshTimer.sv
ramController.sv
fsbController.sv
warpTop.sv
fsb_checker.sv
warpTb.sv
